// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= store_path_tb
FILELIST  ?= tb.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing -j 0
PASS_MSG  ?= Done: no errors

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator, run it and check the result"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"
	@echo "overridable: VERILATOR TOP FILELIST BUILD_DIR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

// ==== design/axil_store_master.sv ====
module axil_store_master
    import store_pkg::*;
(
    input  logic          clk,
    input  logic          rst_n,
    input  logic          deq_valid,
    output logic          deq_ready,
    input  logic [31:0]   deq_addr,
    input  logic [31:0]   deq_data,
    input  logic [3:0]    deq_strb,
    input  store_target_e deq_target,
    output logic          awvalid,
    input  logic          awready,
    output logic [31:0]   awaddr,
    output logic [2:0]    awprot,
    output logic          wvalid,
    input  logic          wready,
    output logic [31:0]   wdata,
    output logic [3:0]    wstrb,
    input  logic          bvalid,
    output logic          bready,
    input  logic [1:0]    bresp,
    output logic          counter_reset
);

    logic [1:0] state;
    logic       aw_done;
    logic       w_done;
    logic       start_write;

    // a channel counts as done once its valid is low or its handshake happens now
    assign aw_done     = !awvalid || awready;
    assign w_done      = !wvalid || wready;
    assign start_write = (state == ms_idle) && deq_valid && (deq_target != tgt_counter);

    // ##############################
    // control FSM
    // ##############################

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state   <= ms_idle;
            awvalid <= 1'b0;
            wvalid  <= 1'b0;
        end else begin
            case (state)
                ms_idle: begin
                    if (start_write) begin
                        state   <= ms_addr_data;
                        awvalid <= 1'b1;
                        wvalid  <= 1'b1;
                    end else if (deq_valid) begin
                        state <= ms_pulse;
                    end
                end
                ms_addr_data: begin
                    if (awready) awvalid <= 1'b0;
                    if (wready) wvalid <= 1'b0;
                    if (aw_done && w_done) state <= ms_resp;
                end
                ms_resp: begin
                    if (bvalid) state <= ms_idle; // bresp is taken but ignored
                end
                default: begin
                    state <= ms_idle;
                end
            endcase
        end
    end

    // the write payload is latched when the FSM leaves idle
    always_ff @(posedge clk) begin
        if (start_write) begin
            awaddr <= deq_addr;
            wdata  <= deq_data;
            wstrb  <= deq_strb;
        end
    end

    assign awprot        = 3'b000;
    assign bready        = (state == ms_resp);
    assign counter_reset = (state == ms_pulse);
    assign deq_ready     = (state == ms_pulse) || ((state == ms_resp) && bvalid);

endmodule

// ==== design/store_path_top.sv ====
module store_path_top
    import store_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  logic        st_valid,
    output logic        st_ready,
    input  logic [31:0] st_addr,
    input  logic [31:0] st_rs2,
    input  logic [4:0]  st_funct5,
    input  logic [2:0]  st_funct3,
    input  logic        pc30,
    output logic        awvalid,
    input  logic        awready,
    output logic [31:0] awaddr,
    output logic [2:0]  awprot,
    output logic        wvalid,
    input  logic        wready,
    output logic [31:0] wdata,
    output logic [3:0]  wstrb,
    input  logic        bvalid,
    output logic        bready,
    input  logic [1:0]  bresp,
    output logic        counter_reset
);

    logic          enq_valid;
    logic          enq_ready;
    logic [31:0]   enq_addr;
    logic [31:0]   enq_data;
    logic [3:0]    enq_strb;
    store_target_e enq_target;

    logic          deq_valid;
    logic          deq_ready;
    logic [31:0]   deq_addr;
    logic [31:0]   deq_data;
    logic [3:0]    deq_strb;
    store_target_e deq_target;

    // ##############################
    // decode, queue, drain
    // ##############################

    store_wsel i_store_wsel (
        .st_valid   (st_valid),
        .st_addr    (st_addr),
        .st_rs2     (st_rs2),
        .st_funct5  (st_funct5),
        .st_funct3  (st_funct3),
        .pc30       (pc30),
        .st_ready   (st_ready),
        .enq_valid  (enq_valid),
        .enq_addr   (enq_addr),
        .enq_data   (enq_data),
        .enq_strb   (enq_strb),
        .enq_target (enq_target),
        .enq_ready  (enq_ready)
    );

    store_queue i_store_queue (
        .clk        (clk),
        .rst_n      (rst_n),
        .enq_valid  (enq_valid),
        .enq_ready  (enq_ready),
        .enq_addr   (enq_addr),
        .enq_data   (enq_data),
        .enq_strb   (enq_strb),
        .enq_target (enq_target),
        .deq_valid  (deq_valid),
        .deq_ready  (deq_ready),
        .deq_addr   (deq_addr),
        .deq_data   (deq_data),
        .deq_strb   (deq_strb),
        .deq_target (deq_target)
    );

    axil_store_master i_axil_store_master (
        .clk           (clk),
        .rst_n         (rst_n),
        .deq_valid     (deq_valid),
        .deq_ready     (deq_ready),
        .deq_addr      (deq_addr),
        .deq_data      (deq_data),
        .deq_strb      (deq_strb),
        .deq_target    (deq_target),
        .awvalid       (awvalid),
        .awready       (awready),
        .awaddr        (awaddr),
        .awprot        (awprot),
        .wvalid        (wvalid),
        .wready        (wready),
        .wdata         (wdata),
        .wstrb         (wstrb),
        .bvalid        (bvalid),
        .bready        (bready),
        .bresp         (bresp),
        .counter_reset (counter_reset)
    );

endmodule

// ==== design/store_pkg.sv ====
package store_pkg;

    // ##############################
    // instruction fields
    // ##############################

    localparam logic [4:0] opc_store_5 = 5'b01000; // opcode bits 6 to 2 of a store

    localparam logic [2:0] fnc_sb = 3'b000;
    localparam logic [2:0] fnc_sh = 3'b001;
    localparam logic [2:0] fnc_sw = 3'b010;

    // ##############################
    // address map
    // ##############################

    localparam logic [2:0] io_sel_uart    = 3'd1;
    localparam logic [2:0] io_sel_counter = 3'd3;

    typedef enum logic [1:0] {
        tgt_dmem,
        tgt_imem,
        tgt_uart,
        tgt_counter
    } store_target_e;

    typedef struct packed {
        logic        io;       // bit 31 selects the io region
        logic        pad_30;
        logic        imem;     // bit 29
        logic        dmem;     // bit 28
        logic [21:0] pad_27_6;
        logic [2:0]  io_sel;   // picks the device inside the io region
        logic        pad_2;
        logic [1:0]  byte_off;
    } mem_addr_io_s;

    typedef union packed {
        logic [31:0]  raw;
        mem_addr_io_s io_v;
    } mem_addr_u;

    // ##############################
    // store queue and bus master
    // ##############################

    localparam int stq_depth = 4;
    localparam int stq_ptr_w = $clog2(stq_depth);

    localparam logic [1:0] ms_idle      = 2'd0;
    localparam logic [1:0] ms_addr_data = 2'd1;
    localparam logic [1:0] ms_resp      = 2'd2;
    localparam logic [1:0] ms_pulse     = 2'd3;

endpackage

// ==== design/store_queue.sv ====
module store_queue
    import store_pkg::*;
(
    input  logic          clk,
    input  logic          rst_n,
    input  logic          enq_valid,
    output logic          enq_ready,
    input  logic [31:0]   enq_addr,
    input  logic [31:0]   enq_data,
    input  logic [3:0]    enq_strb,
    input  store_target_e enq_target,
    output logic          deq_valid,
    input  logic          deq_ready,
    output logic [31:0]   deq_addr,
    output logic [31:0]   deq_data,
    output logic [3:0]    deq_strb,
    output store_target_e deq_target
);

    logic [31:0]   addr_mem [stq_depth];
    logic [31:0]   data_mem [stq_depth];
    logic [3:0]    strb_mem [stq_depth];
    store_target_e tgt_mem  [stq_depth];

    logic [stq_ptr_w-1:0] wr_ptr;
    logic [stq_ptr_w-1:0] rd_ptr;
    logic [stq_ptr_w:0]   count;
    logic                 push;
    logic                 pop;

    assign enq_ready = (count != (stq_ptr_w + 1)'(stq_depth));
    assign deq_valid = (count != '0);
    assign push      = enq_valid && enq_ready;
    assign pop       = deq_valid && deq_ready;

    always_ff @(posedge clk) begin
        if (push) begin
            addr_mem[wr_ptr] <= enq_addr;
            data_mem[wr_ptr] <= enq_data;
            strb_mem[wr_ptr] <= enq_strb;
            tgt_mem[wr_ptr]  <= enq_target;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == stq_ptr_w'(stq_depth - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == stq_ptr_w'(stq_depth - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: ; // push and pop together leave the count alone
            endcase
        end
    end

    // head entry straight from storage, a new entry shows up one cycle after its push
    assign deq_addr   = addr_mem[rd_ptr];
    assign deq_data   = data_mem[rd_ptr];
    assign deq_strb   = strb_mem[rd_ptr];
    assign deq_target = tgt_mem[rd_ptr];

endmodule

// ==== design/store_wsel.sv ====
module store_wsel
    import store_pkg::*;
(
    input  logic          st_valid,
    input  logic [31:0]   st_addr,
    input  logic [31:0]   st_rs2,
    input  logic [4:0]    st_funct5,
    input  logic [2:0]    st_funct3,
    input  logic          pc30,
    output logic          st_ready,
    output logic          enq_valid,
    output logic [31:0]   enq_addr,
    output logic [31:0]   enq_data,
    output logic [3:0]    enq_strb,
    output store_target_e enq_target,
    input  logic          enq_ready
);

    mem_addr_u   addr_u;
    logic [3:0]  wea;
    logic [31:0] lane_data;
    logic        is_store;
    logic        uart_hit;
    logic        cnt_hit;
    logic        imem_hit;
    logic        dmem_hit;
    logic        tgt_hit;

    assign addr_u.raw = st_addr;
    assign is_store   = (st_funct5 == opc_store_5);

    // ##############################
    // lane alignment and strobes
    // ##############################

    always_comb begin
        wea       = 4'b0000;
        lane_data = st_rs2;
        if (is_store) begin
            case (st_funct3)
                fnc_sb: begin
                    case (addr_u.io_v.byte_off)
                        2'b00: begin
                            wea       = 4'b0001;
                            lane_data = {24'b0, st_rs2[7:0]};
                        end
                        2'b01: begin
                            wea       = 4'b0010;
                            lane_data = {16'b0, st_rs2[7:0], 8'b0};
                        end
                        2'b10: begin
                            wea       = 4'b0100;
                            lane_data = {8'b0, st_rs2[7:0], 16'b0};
                        end
                        default: begin
                            wea       = 4'b1000;
                            lane_data = {st_rs2[7:0], 24'b0};
                        end
                    endcase
                end
                fnc_sh: begin
                    if (addr_u.io_v.byte_off[1]) begin
                        wea       = 4'b1100;
                        lane_data = {st_rs2[15:0], 16'b0};
                    end else begin
                        wea       = 4'b0011;
                        lane_data = {16'b0, st_rs2[15:0]};
                    end
                end
                fnc_sw: begin
                    wea = 4'b1111;
                end
                default: ;
            endcase
        end
    end

    // ##############################
    // target select
    // ##############################

    assign uart_hit = addr_u.io_v.io && (addr_u.io_v.io_sel == io_sel_uart);
    assign cnt_hit  = addr_u.io_v.io && (addr_u.io_v.io_sel == io_sel_counter);
    assign imem_hit = addr_u.io_v.imem && pc30; // imem is writable only while pc30 is set
    assign dmem_hit = addr_u.io_v.dmem;

    always_comb begin
        enq_target = tgt_dmem;
        enq_strb   = wea;
        tgt_hit    = 1'b1;
        if (uart_hit) begin
            enq_target = tgt_uart;
            enq_strb   = {3'b000, wea[0]}; // the uart only takes byte lane 0
        end else if (cnt_hit) begin
            enq_target = tgt_counter;
        end else if (imem_hit) begin
            enq_target = tgt_imem;
        end else if (!dmem_hit) begin
            tgt_hit = 1'b0;
        end
    end

    assign enq_valid = st_valid && tgt_hit && (enq_strb != 4'b0000);
    assign enq_addr  = {addr_u.raw[31:2], 2'b00};
    assign enq_data  = lane_data;
    assign st_ready  = enq_ready; // dropped requests are still taken when the queue has room

endmodule

// ==== include/store_path_checks.svh ====
`ifndef store_path_checks_svh
`define store_path_checks_svh

// ##############################
// expected traffic, in issue order
// ##############################

typedef struct {
    logic        pulse;
    logic [31:0] addr;
    logic [31:0] data;
    logic [3:0]  strb;
} exp_entry_t;

exp_entry_t exp_q[$];
int         value_errors = 0;
int         flow_errors  = 0;
int         pulses_seen  = 0;
int         pulses_exp   = 0;

function automatic void expect_write(input logic [31:0] addr, input logic [31:0] data,
                                     input logic [3:0] strb);
    exp_q.push_back('{1'b0, addr, data, strb});
endfunction

function automatic void expect_pulse();
    exp_q.push_back('{1'b1, 32'h0, 32'h0, 4'h0});
    pulses_exp++;
endfunction

// ##############################
// compare tasks
// ##############################

task automatic check_write(input logic [31:0] got_addr, input logic [31:0] got_data,
                           input logic [3:0] got_strb);
    exp_entry_t e;
    if (exp_q.size() == 0) begin
        $display("extra bus write to %h with no store left to match it", got_addr);
        flow_errors++;
        return;
    end
    e = exp_q.pop_front();
    if (e.pulse) begin
        $display("bus write to %h came where a counter reset pulse was due", got_addr);
        flow_errors++;
        return;
    end
    if (got_addr !== e.addr) begin
        $display("ERROR awaddr got %h expected %h", got_addr, e.addr);
        value_errors++;
    end
    if (got_data !== e.data) begin
        $display("ERROR wdata got %h expected %h", got_data, e.data);
        value_errors++;
    end
    if (got_strb !== e.strb) begin
        $display("ERROR wstrb got %h expected %h", got_strb, e.strb);
        value_errors++;
    end
endtask

task automatic check_prot(input logic [2:0] got_prot);
    if (got_prot !== 3'b000) begin // every write is an unprivileged secure data access
        $display("ERROR awprot got %h expected %h", got_prot, 3'b000);
        value_errors++;
    end
endtask

task automatic take_pulse();
    pulses_seen++;
    if (exp_q.size() == 0 || !exp_q[0].pulse) begin
        $display("counter_reset pulsed where no counter reset store was due");
        flow_errors++;
    end else begin
        void'(exp_q.pop_front());
    end
endtask

task automatic check_target_pulse(input int got, input int exp);
    if (got != exp) begin
        $display("ERROR counter_reset pulses got %h expected %h", got, exp);
        value_errors++;
    end
endtask

`endif

// ==== dv/store_path_tb.sv ====
module store_path_tb
    import store_pkg::*;
();

    localparam int n_stores    = 4 + 3 + 3 + 5 + 5 + 8; // stores issued by the six tests
    localparam int cycle_limit = 8 * n_stores + 200;

    logic        clk;
    logic        rst_n;
    logic        st_valid;
    logic        st_ready;
    logic [31:0] st_addr;
    logic [31:0] st_rs2;
    logic [4:0]  st_funct5;
    logic [2:0]  st_funct3;
    logic        pc30;
    logic        awvalid;
    logic        awready;
    logic [31:0] awaddr;
    logic [2:0]  awprot;
    logic        wvalid;
    logic        wready;
    logic [31:0] wdata;
    logic [3:0]  wstrb;
    logic        bvalid;
    logic        bready;
    logic [1:0]  bresp;
    logic        counter_reset;

    integer      seed = 37412;
    logic        slow_slave = 1'b0; // long AW, W and B delays for the back-pressure burst
    int          stalls;

    `include "store_path_checks.svh"

    store_path_top i_store_path_top (
        .clk           (clk),
        .rst_n         (rst_n),
        .st_valid      (st_valid),
        .st_ready      (st_ready),
        .st_addr       (st_addr),
        .st_rs2        (st_rs2),
        .st_funct5     (st_funct5),
        .st_funct3     (st_funct3),
        .pc30          (pc30),
        .awvalid       (awvalid),
        .awready       (awready),
        .awaddr        (awaddr),
        .awprot        (awprot),
        .wvalid        (wvalid),
        .wready        (wready),
        .wdata         (wdata),
        .wstrb         (wstrb),
        .bvalid        (bvalid),
        .bready        (bready),
        .bresp         (bresp),
        .counter_reset (counter_reset)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    initial begin : watchdog
        int cycles;
        cycles = 0;
        while (cycles < cycle_limit) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout: the run did not finish within %0d clock cycles", cycle_limit);
        $display("Done: errors found");
        $finish;
    end

    // ##############################
    // AXI4-Lite write slave
    // ##############################

    function automatic int rand_delay();
        int span;
        span = slow_slave ? 8 : 3;
        return (slow_slave ? 2 : 0) + int'($unsigned($random(seed)) % span);
    endfunction

    initial begin : axi_slave
        int          aw_wait;
        int          w_wait;
        int          b_wait;
        logic        aw_taken;
        logic        w_taken;
        logic        b_fire;
        logic [31:0] got_addr;
        logic [31:0] got_data;
        logic [3:0]  got_strb;
        awready  = 1'b0;
        wready   = 1'b0;
        bvalid   = 1'b0;
        bresp    = 2'b00;
        aw_taken = 1'b0;
        w_taken  = 1'b0;
        b_fire   = 1'b0;
        got_addr = '0;
        got_data = '0;
        got_strb = '0;
        aw_wait  = rand_delay();
        w_wait   = rand_delay();
        b_wait   = rand_delay();
        forever begin
            @(negedge clk);
            awready = 1'b0;
            wready  = 1'b0;
            if (counter_reset) take_pulse(); // one low phase per pulse
            if (b_fire) begin
                bvalid = 1'b0;
                b_fire = 1'b0;
            end else if (aw_taken && w_taken && !bvalid) begin
                if (b_wait == 0) bvalid = 1'b1;
                else b_wait--;
            end
            if (awvalid && !aw_taken) begin
                if (aw_wait == 0) begin
                    awready  = 1'b1;
                    aw_taken = 1'b1;
                    got_addr = awaddr;
                    check_prot(awprot);
                end else begin
                    aw_wait--;
                end
            end
            if (wvalid && !w_taken) begin
                if (w_wait == 0) begin
                    wready   = 1'b1;
                    w_taken  = 1'b1;
                    got_data = wdata;
                    got_strb = wstrb;
                end else begin
                    w_wait--;
                end
            end
            if (bvalid && bready) begin // the write completes on the coming rising edge
                check_write(got_addr, got_data, got_strb);
                b_fire   = 1'b1;
                aw_taken = 1'b0;
                w_taken  = 1'b0;
                aw_wait  = rand_delay();
                w_wait   = rand_delay();
                b_wait   = rand_delay();
            end
        end
    end

    // ##############################
    // expected model and stimulus
    // ##############################

    function automatic void model_store(input logic [31:0] addr, input logic [31:0] rs2,
                                        input logic [4:0] f5, input logic [2:0] f3,
                                        input logic pc);
        mem_addr_u   a;
        logic [3:0]  strb;
        logic [31:0] data;
        logic [31:0] word_addr;
        a.raw     = addr;
        word_addr = {addr[31:2], 2'b00};
        strb      = 4'b0000;
        data      = 32'h0;
        if (f5 == opc_store_5) begin
            case (f3)
                fnc_sb: begin
                    strb = 4'b0001 << a.io_v.byte_off;
                    data = {24'h0, rs2[7:0]} << (5'd8 * a.io_v.byte_off);
                end
                fnc_sh: begin
                    strb = 4'b0011 << (a.io_v.byte_off[1] ? 2 : 0);
                    data = {16'h0, rs2[15:0]} << (a.io_v.byte_off[1] ? 16 : 0);
                end
                fnc_sw: begin
                    strb = 4'b1111;
                    data = rs2;
                end
                default: ;
            endcase
        end
        if (strb == 4'b0000) return;
        if (a.io_v.io && (a.io_v.io_sel == io_sel_uart)) begin
            if (strb[0]) expect_write(word_addr, data, 4'b0001);
        end else if (a.io_v.io && (a.io_v.io_sel == io_sel_counter)) begin
            expect_pulse();
        end else if (a.io_v.imem && pc) begin
            expect_write(word_addr, data, strb);
        end else if (a.io_v.dmem) begin
            expect_write(word_addr, data, strb);
        end
    endfunction

    task automatic drive_store(input logic [31:0] addr, input logic [31:0] rs2,
                               input logic [4:0] f5, input logic [2:0] f3, input logic pc);
        model_store(addr, rs2, f5, f3, pc);
        st_valid  = 1'b1;
        st_addr   = addr;
        st_rs2    = rs2;
        st_funct5 = f5;
        st_funct3 = f3;
        pc30      = pc;
        while (!st_ready) begin
            stalls++;
            @(negedge clk); // the request is held until the queue has room
        end
        @(negedge clk);
        st_valid = 1'b0;
    endtask

    task automatic wait_drain();
        while (exp_q.size() != 0) @(negedge clk);
    endtask

    // ##############################
    // directed tests
    // ##############################

    task automatic byte_lane_stores();
        int off;
        for (off = 0; off < 4; off++) begin
            drive_store(32'h1000_0040 + off, 32'hA5C3_5A10 + off, opc_store_5, fnc_sb, 1'b0);
        end
        wait_drain();
    endtask

    task automatic half_and_word_stores();
        drive_store(32'h1000_0100, 32'hDEAD_BEEF, opc_store_5, fnc_sh, 1'b0);
        drive_store(32'h1000_0102, 32'h0000_CAFE, opc_store_5, fnc_sh, 1'b0);
        drive_store(32'h1000_0107, 32'h0BAD_F00D, opc_store_5, fnc_sw, 1'b0);
        wait_drain();
    endtask

    task automatic imem_gating();
        drive_store(32'h2000_0010, 32'h1357_9BDF, opc_store_5, fnc_sw, 1'b1);
        drive_store(32'h2000_0014, 32'h2468_ACE0, opc_store_5, fnc_sw, 1'b0);
        drive_store(32'h1000_0200, 32'h0000_0001, opc_store_5, fnc_sw, 1'b0); // marker write
        wait_drain();
    endtask

    task automatic io_targets();
        drive_store(32'h8000_0008, 32'h0000_0041, opc_store_5, fnc_sb, 1'b0);
        drive_store(32'h8000_0008, 32'h1234_5678, opc_store_5, fnc_sw, 1'b0);
        drive_store(32'h1000_0300, 32'h1111_1111, opc_store_5, fnc_sw, 1'b0);
        drive_store(32'h8000_0018, 32'h0000_0000, opc_store_5, fnc_sw, 1'b0);
        drive_store(32'h1000_0304, 32'h2222_2222, opc_store_5, fnc_sw, 1'b0);
        wait_drain();
    endtask

    task automatic dropped_requests();
        drive_store(32'h1000_0400, 32'hBAD0_0001, 5'b00000, fnc_sw, 1'b0); // load opcode
        drive_store(32'h0000_0400, 32'hBAD0_0002, opc_store_5, fnc_sw, 1'b0);
        drive_store(32'h1000_0404, 32'hBAD0_0003, opc_store_5, 3'b011, 1'b0);
        drive_store(32'h8000_0010, 32'hBAD0_0004, opc_store_5, fnc_sw, 1'b0);
        drive_store(32'h1000_0408, 32'h600D_0005, opc_store_5, fnc_sw, 1'b0); // marker write
        wait_drain();
    endtask

    task automatic backpressure_burst();
        int i;
        slow_slave = 1'b1;
        stalls     = 0;
        for (i = 0; i < 8; i++) begin
            drive_store(32'h1000_0800 + 5 * i, 32'hC0DE_0000 + 32'h0101 * i, opc_store_5,
                        (i % 3 == 0) ? fnc_sb : ((i % 3 == 1) ? fnc_sh : fnc_sw), 1'b0);
        end
        wait_drain();
        if (stalls == 0) begin
            $display("st_ready never dropped during the burst of stores");
            flow_errors++;
        end
        slow_slave = 1'b0;
    endtask

    initial begin
        rst_n      = 1'b0;
        st_valid   = 1'b0;
        st_addr    = '0;
        st_rs2     = '0;
        st_funct5  = '0;
        st_funct3  = '0;
        pc30       = 1'b0;
        slow_slave = 1'b0;
        stalls     = 0;
        repeat (3) @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);
        if (!st_ready || awvalid || wvalid || bready || counter_reset) begin
            $display("handshake outputs are not idle after reset");
            flow_errors++;
        end
        byte_lane_stores();
        half_and_word_stores();
        imem_gating();
        io_targets();
        dropped_requests();
        backpressure_burst();
        check_target_pulse(pulses_seen, pulses_exp);
        $display("errors: %0d wrong values, %0d missing, extra or out of order",
                 value_errors, flow_errors);
        if (value_errors + flow_errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

// ==== tb.f ====
+incdir+include
design/store_pkg.sv
design/store_wsel.sv
design/store_queue.sv
design/axil_store_master.sv
design/store_path_top.sv
dv/store_path_tb.sv
